// File: source/pipe_pkg.sv
package pipe_pkg;

    localparam int isa_width      = 32;    // data and pc width
    localparam int reg_addr_width = 3;     // register index width
    localparam int num_regs       = 8;     // r0 reads as zero
    localparam int imm_width      = 16;    // signed immediate in instr[15:0]
    localparam int opcode_width   = 4;

    // field positions in the instruction word
    localparam int opcode_lsb = 28;        // instr[31:28]
    localparam int dest_lsb   = 25;        // instr[27:25]
    localparam int src1_lsb   = 22;        // instr[24:22]
    localparam int src2_lsb   = 19;        // instr[21:19]

    typedef enum logic [opcode_width-1:0] {
        op_add  = 4'h0,
        op_sub  = 4'h1,
        op_and  = 4'h2,
        op_or   = 4'h3,
        op_xor  = 4'h4,
        op_slt  = 4'h5,                    // signed compare
        op_addi = 4'h6,                    // src1 + sext(imm)
        op_beq  = 4'h7,
        op_bne  = 4'h8,
        op_nop  = 4'hf
    } opcode_e;

    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,                    // also used for branch compare
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_xor = 3'd4,
        alu_slt = 3'd5
    } alu_op_e;

    typedef struct packed {
        logic [isa_width-1:0] pc;
        logic [isa_width-1:0] instr;
    } fetch_t;                             // 64 bits from fetch

    typedef struct packed {
        logic                      valid;          // 0 marks a bubble
        logic [isa_width-1:0]      pc;
        alu_op_e                   alu_op;
        logic [isa_width-1:0]      operand_1;
        logic [isa_width-1:0]      operand_2;      // reg or sext imm
        logic [isa_width-1:0]      branch_offset;  // sext imm
        logic                      is_branch;
        logic                      branch_ne;      // 1 for bne
        logic                      reg_write;
        logic [reg_addr_width-1:0] dest;
    } id_ex_t;

    typedef struct packed {
        logic [isa_width-1:0]      pc;
        logic [reg_addr_width-1:0] dest;
        logic [isa_width-1:0]      value;
        logic                      reg_write;
        logic                      branch_taken;
        logic [isa_width-1:0]      target;         // pc + branch_offset
    } result_t;

endpackage

// File: source/reg_file.sv
`timescale 1ns/1ps

module reg_file import pipe_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n,

    input  logic [reg_addr_width-1:0] rd_addr_1,   // from decode src1
    input  logic [reg_addr_width-1:0] rd_addr_2,   // from decode src2
    output logic [isa_width-1:0]      rd_data_1,
    output logic [isa_width-1:0]      rd_data_2,

    input  logic                      wr_en,       // from retire stage
    input  logic [reg_addr_width-1:0] wr_addr,
    input  logic [isa_width-1:0]      wr_data
);

    logic [isa_width-1:0] regs [num_regs];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;                     // every entry back to zero
            end
        end else if (wr_en && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;              // r0 never written
        end
    end

    // asynchronous reads
    // r0 forced to zero even if the array holds something else
    always_comb begin
        if (rd_addr_1 == '0) begin
            rd_data_1 = '0;
        end else begin
            rd_data_1 = regs[rd_addr_1];
        end
    end

    always_comb begin
        if (rd_addr_2 == '0) begin
            rd_data_2 = '0;
        end else begin
            rd_data_2 = regs[rd_addr_2];
        end
    end

endmodule

// File: source/instr_decode.sv
`timescale 1ns/1ps

module instr_decode import pipe_pkg::*; (
    input  logic                      in_valid,    // fetch handshake valid
    input  fetch_t                    in_data,

    output logic [reg_addr_width-1:0] rd_addr_1,   // to reg_file
    output logic [reg_addr_width-1:0] rd_addr_2,
    input  logic [isa_width-1:0]      rd_data_1,
    input  logic [isa_width-1:0]      rd_data_2,

    input  logic                      fwd_en,      // ex stage writes a reg
    input  logic [reg_addr_width-1:0] fwd_dest,
    input  logic [isa_width-1:0]      fwd_value,   // alu result in ex

    input  logic                      annul,       // taken branch in ex
    output id_ex_t                    decoded
);

    opcode_e                   opcode;
    logic [reg_addr_width-1:0] dest;
    logic [reg_addr_width-1:0] src1;
    logic [reg_addr_width-1:0] src2;
    logic [isa_width-1:0]      imm_ext;
    logic [isa_width-1:0]      reg_1;
    logic [isa_width-1:0]      reg_2;
    logic                      fwd_1;
    logic                      fwd_2;
    alu_op_e                   alu_op;
    logic                      is_branch;
    logic                      branch_ne;
    logic                      reg_write;
    logic                      use_imm;

    assign opcode  = opcode_e'(in_data.instr[opcode_lsb +: opcode_width]);
    assign dest    = in_data.instr[dest_lsb +: reg_addr_width];
    assign src1    = in_data.instr[src1_lsb +: reg_addr_width];
    assign src2    = in_data.instr[src2_lsb +: reg_addr_width];
    assign imm_ext = {{(isa_width-imm_width){in_data.instr[imm_width-1]}},
                      in_data.instr[imm_width-1:0]};

    assign rd_addr_1 = src1;
    assign rd_addr_2 = src2;

    // ex stage result bypasses the reg file, r0 never forwarded
    assign fwd_1 = fwd_en && (fwd_dest == src1) && (src1 != '0);
    assign fwd_2 = fwd_en && (fwd_dest == src2) && (src2 != '0);
    assign reg_1 = fwd_1 ? fwd_value : rd_data_1;
    assign reg_2 = fwd_2 ? fwd_value : rd_data_2;

    always_comb begin
        alu_op    = alu_add;                       // defaults give a nop
        is_branch = 1'b0;
        branch_ne = 1'b0;
        reg_write = 1'b0;
        use_imm   = 1'b0;
        case (opcode)
            op_add: begin
                reg_write = 1'b1;
            end
            op_sub: begin
                alu_op    = alu_sub;
                reg_write = 1'b1;
            end
            op_and: begin
                alu_op    = alu_and;
                reg_write = 1'b1;
            end
            op_or: begin
                alu_op    = alu_or;
                reg_write = 1'b1;
            end
            op_xor: begin
                alu_op    = alu_xor;
                reg_write = 1'b1;
            end
            op_slt: begin
                alu_op    = alu_slt;
                reg_write = 1'b1;
            end
            op_addi: begin
                use_imm   = 1'b1;                  // imm replaces src2
                reg_write = 1'b1;
            end
            op_beq: begin
                alu_op    = alu_sub;               // equal when difference is zero
                is_branch = 1'b1;
            end
            op_bne: begin
                alu_op    = alu_sub;
                is_branch = 1'b1;
                branch_ne = 1'b1;
            end
            default: begin                         // op_nop and unknown codes
            end
        endcase
    end

    always_comb begin
        decoded.valid         = in_valid & ~annul; // killed behind a taken branch
        decoded.pc            = in_data.pc;
        decoded.alu_op        = alu_op;
        decoded.operand_1     = reg_1;
        decoded.operand_2     = use_imm ? imm_ext : reg_2;
        decoded.branch_offset = imm_ext;
        decoded.is_branch     = is_branch;
        decoded.branch_ne     = branch_ne;
        decoded.reg_write     = reg_write & (dest != '0);  // r0 writes dropped here
        decoded.dest          = dest;
    end

endmodule

// File: source/id_ex_reg.sv
`timescale 1ns/1ps

module id_ex_reg import pipe_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,

    input  logic   stall,       // output side back-pressure
    input  logic   in_valid,    // an instruction is offered this cycle
    input  id_ex_t decoded,     // from instr_decode
    output id_ex_t ex           // to exec_unit and forwarding
);

    // valid is control state and always gets cleared on reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex.valid <= 1'b0;                      // start with a bubble
        end else if (!stall) begin
            ex.valid <= in_valid & decoded.valid;  // annulled items become bubbles
        end
    end

    // payload follows decode on every accepted instruction
    // a bubble keeps the old payload since valid masks it downstream
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex.pc            <= '0;
            ex.alu_op        <= alu_add;
            ex.operand_1     <= '0;
            ex.operand_2     <= '0;
            ex.branch_offset <= '0;
            ex.is_branch     <= 1'b0;
            ex.branch_ne     <= 1'b0;
            ex.reg_write     <= 1'b0;
            ex.dest          <= '0;
        end else if (!stall && in_valid) begin
            ex.pc            <= decoded.pc;
            ex.alu_op        <= decoded.alu_op;
            ex.operand_1     <= decoded.operand_1;
            ex.operand_2     <= decoded.operand_2;
            ex.branch_offset <= decoded.branch_offset;
            ex.is_branch     <= decoded.is_branch;
            ex.branch_ne     <= decoded.branch_ne;
            ex.reg_write     <= decoded.reg_write;
            ex.dest          <= decoded.dest;
        end
    end

endmodule

// File: source/exec_unit.sv
`timescale 1ns/1ps

module exec_unit import pipe_pkg::*; (
    input  id_ex_t  ex,             // stage register contents
    output result_t result,         // to result_reg
    output logic    result_valid,
    output logic    branch_taken    // annuls the instruction in decode
);

    logic [isa_width-1:0] alu_out;
    logic                 slt_bit;
    logic                 zero;
    logic                 cond_met;

    assign slt_bit = $signed(ex.operand_1) < $signed(ex.operand_2);

    always_comb begin
        case (ex.alu_op)
            alu_add: alu_out = ex.operand_1 + ex.operand_2;
            alu_sub: alu_out = ex.operand_1 - ex.operand_2;
            alu_and: alu_out = ex.operand_1 & ex.operand_2;
            alu_or:  alu_out = ex.operand_1 | ex.operand_2;
            alu_xor: alu_out = ex.operand_1 ^ ex.operand_2;
            alu_slt: alu_out = {{(isa_width-1){1'b0}}, slt_bit};  // 0 or 1
            default: alu_out = ex.operand_1 + ex.operand_2;
        endcase
    end

    // branch sense
    // beq takes on a zero difference and bne on a nonzero one
    assign zero     = (alu_out == '0);
    assign cond_met = ex.branch_ne ? ~zero : zero;

    assign result_valid = ex.valid;
    assign branch_taken = ex.valid & ex.is_branch & cond_met;  // bubbles never branch

    always_comb begin
        result.pc           = ex.pc;
        result.dest         = ex.dest;
        result.value        = alu_out;             // also the forwarded value
        result.reg_write    = ex.reg_write;
        result.branch_taken = branch_taken;
        result.target       = ex.pc + ex.branch_offset;
    end

endmodule

// File: source/result_reg.sv
`timescale 1ns/1ps

module result_reg import pipe_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,

    input  logic    stall,          // out_valid high and out_ready low
    input  logic    result_valid,   // ex stage holds a live instruction
    input  result_t result,         // from exec_unit

    output logic    out_valid,      // result stream
    output result_t out_data,
    output logic    wr_en           // reg file write strobe
);

    // out_valid drops on an unstalled edge with nothing behind it
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (!stall) begin
            out_valid <= result_valid;
        end
    end

    // held steady while the consumer is not ready
    always_ff @(posedge clk) begin
        if (!stall && result_valid) begin
            out_data <= result;
        end
    end

    // write-back on the same edge that retires the instruction
    // so a reader one cycle behind sees the new value in the reg file
    assign wr_en = ~stall & result_valid & result.reg_write & (result.dest != '0);

endmodule

// File: source/core_pipe.sv
`timescale 1ns/1ps

module core_pipe import pipe_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,

    input  logic    in_valid,       // fetch side
    output logic    in_ready,
    input  fetch_t  in_data,

    output logic    out_valid,      // retire side
    input  logic    out_ready,
    output result_t out_data
);

    logic                      stall;
    logic [reg_addr_width-1:0] rd_addr_1;
    logic [reg_addr_width-1:0] rd_addr_2;
    logic [isa_width-1:0]      rd_data_1;
    logic [isa_width-1:0]      rd_data_2;
    id_ex_t                    decoded;
    id_ex_t                    ex;
    result_t                   result;
    logic                      result_valid;
    logic                      branch_taken;
    logic                      wr_en;

    assign stall    = out_valid & ~out_ready;      // freezes every stage
    assign in_ready = ~stall;

    reg_file reg_file_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_addr_1 (rd_addr_1),
        .rd_addr_2 (rd_addr_2),
        .rd_data_1 (rd_data_1),
        .rd_data_2 (rd_data_2),
        .wr_en     (wr_en),
        .wr_addr   (result.dest),                  // write-back comes from the ex result
        .wr_data   (result.value)
    );

    instr_decode instr_decode_i (
        .in_valid  (in_valid),
        .in_data   (in_data),
        .rd_addr_1 (rd_addr_1),
        .rd_addr_2 (rd_addr_2),
        .rd_data_1 (rd_data_1),
        .rd_data_2 (rd_data_2),
        .fwd_en    (ex.valid & ex.reg_write),      // only a live writer forwards
        .fwd_dest  (ex.dest),
        .fwd_value (result.value),
        .annul     (branch_taken),
        .decoded   (decoded)
    );

    id_ex_reg id_ex_reg_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .stall    (stall),
        .in_valid (in_valid),
        .decoded  (decoded),
        .ex       (ex)
    );

    exec_unit exec_unit_i (
        .ex           (ex),
        .result       (result),
        .result_valid (result_valid),
        .branch_taken (branch_taken)
    );

    result_reg result_reg_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .stall        (stall),
        .result_valid (result_valid),
        .result       (result),
        .out_valid    (out_valid),
        .out_data     (out_data),
        .wr_en        (wr_en)
    );

endmodule

// File: sim/core_pipe_asserts.sv
`timescale 1ns/1ps

module core_pipe_asserts import pipe_pkg::*; (
    input logic    clk,
    input logic    rst_n,
    input logic    in_ready,
    input logic    out_valid,
    input logic    out_ready,
    input logic    stall,
    input result_t out_data
);

    // a reset edge leaves the result stream empty
    reset_quiet: assert property (@(posedge clk) !rst_n |=> !out_valid)
        else $error("out_valid high during reset");

    // back-pressure freezes the retire register
    hold_stalled: assert property (@(posedge clk) disable iff (!rst_n)
        stall |=> out_valid && $stable(out_data))
        else $error("out_data changed while the stream was stalled");

    // stall seen from the pins, a full retire register the consumer refuses
    ready_is_not_stall: assert property (@(posedge clk) disable iff (!rst_n)
        in_ready == !(out_valid && !out_ready))
        else $error("in_ready differs from the inverse of stall");

    // writes to r0 must be dropped before they reach the stream
    no_r0_write: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> !(out_data.reg_write && (out_data.dest == '0)))
        else $error("result with dest 0 and reg_write set");

endmodule

bind core_pipe core_pipe_asserts core_pipe_asserts_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .stall     (stall),
    .out_data  (out_data)
);

// File: sim/core_pipe_tb.sv
`timescale 1ns/1ps

module core_pipe_tb import pipe_pkg::*;;

    localparam int num_tests       = 22;
    localparam int watchdog_cycles = 4 * num_tests + 100;

    logic    clk;
    logic    rst_n;
    logic    in_valid;
    logic    in_ready;
    fetch_t  in_data;
    logic    out_valid;
    logic    out_ready;
    result_t out_data;

    fetch_t               tbl      [num_tests];    // stimulus table
    string                tbl_name [num_tests];
    int                   tbl_len;
    logic [isa_width-1:0] ref_regs [num_regs];     // interpreter register state
    result_t              exp_q    [$];            // expected results, program order
    string                name_q   [$];
    logic [31:0]          lfsr_state;
    int                   mismatch_count;
    int                   other_count;

    core_pipe core_pipe_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;       // taps 32 22 2 1
        end
        return s >> 1;
    endfunction

    function automatic logic [isa_width-1:0] encode_instr(input opcode_e op,
            input logic [2:0] d, input logic [2:0] s1, input logic [2:0] s2,
            input logic [15:0] imm);
        return {op, d, s1, s2, 3'b000, imm};       // bits 18:16 unused
    endfunction

    task automatic add_entry(input string name, input opcode_e op, input logic [2:0] d,
            input logic [2:0] s1, input logic [2:0] s2, input logic [15:0] imm);
        tbl[tbl_len].pc    = 32'h0000_1000 + 32'(4 * tbl_len);
        tbl[tbl_len].instr = encode_instr(op, d, s1, s2, imm);
        tbl_name[tbl_len]  = name;
        tbl_len++;
    endtask

    task automatic build_table();
        tbl_len = 0;
        add_entry("addi_pos",      op_addi, 3'd1, 3'd0, 3'd0, 16'd5);
        add_entry("addi_neg",      op_addi, 3'd2, 3'd0, 3'd0, 16'hfffd);
        add_entry("add_fwd",       op_add,  3'd3, 3'd1, 3'd2, 16'd0);   // r2 from ex
        add_entry("sub_fwd",       op_sub,  3'd4, 3'd3, 3'd1, 16'd0);
        add_entry("and_fwd",       op_and,  3'd5, 3'd1, 3'd4, 16'd0);
        add_entry("or_fwd",        op_or,   3'd6, 3'd5, 3'd2, 16'd0);
        add_entry("xor_fwd",       op_xor,  3'd7, 3'd6, 3'd1, 16'd0);
        add_entry("slt_neg_lt",    op_slt,  3'd3, 3'd2, 3'd1, 16'd0);   // -3 < 5
        add_entry("slt_pos_ge",    op_slt,  3'd4, 3'd1, 3'd2, 16'd0);
        add_entry("write_r0",      op_addi, 3'd0, 3'd1, 3'd0, 16'd99);
        add_entry("read_r0",       op_add,  3'd5, 3'd0, 3'd1, 16'd0);
        add_entry("beq_taken",     op_beq,  3'd0, 3'd5, 3'd1, 16'h0020); // r5 forwarded
        add_entry("annul_beq",     op_addi, 3'd6, 3'd0, 3'd0, 16'd77);
        add_entry("bne_taken",     op_bne,  3'd0, 3'd1, 3'd2, 16'hfff8);
        add_entry("annul_bne",     op_addi, 3'd7, 3'd0, 3'd0, 16'd11);
        add_entry("beq_not",       op_beq,  3'd0, 3'd1, 3'd2, 16'h0040);
        add_entry("after_beq_not", op_addi, 3'd6, 3'd6, 3'd0, 16'd1);
        add_entry("bne_not",       op_bne,  3'd0, 3'd5, 3'd1, 16'h0010);
        add_entry("after_bne_not", op_add,  3'd7, 3'd7, 3'd6, 16'd0);
        add_entry("nop",           op_nop,  3'd0, 3'd0, 3'd0, 16'd0);
        add_entry("sub_self",      op_sub,  3'd1, 3'd1, 3'd1, 16'd0);
        add_entry("add_zero_fwd",  op_add,  3'd2, 3'd1, 3'd1, 16'd0);
    endtask

    // sequential model, a taken branch kills the next table entry
    task automatic build_expected();
        logic [isa_width-1:0] instr;
        logic [isa_width-1:0] a;
        logic [isa_width-1:0] b;
        logic [isa_width-1:0] imm;
        logic [2:0]           d;
        opcode_e              opc;
        logic                 annul;
        result_t              r;
        annul = 1'b0;
        for (int i = 0; i < num_regs; i++) begin
            ref_regs[i] = '0;
        end
        for (int i = 0; i < num_tests; i++) begin
            instr    = tbl[i].instr;
            opc      = opcode_e'(instr[31:28]);
            d        = instr[27:25];
            a        = ref_regs[instr[24:22]];
            b        = ref_regs[instr[21:19]];
            imm      = {{16{instr[15]}}, instr[15:0]};
            r        = '0;
            r.pc     = tbl[i].pc;
            r.dest   = d;
            r.target = tbl[i].pc + imm;
            case (opc)
                op_sub:  r.value = a - b;
                op_and:  r.value = a & b;
                op_or:   r.value = a | b;
                op_xor:  r.value = a ^ b;
                op_slt:  r.value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                op_addi: r.value = a + imm;
                op_beq:  r.value = a - b;          // compare by difference
                op_bne:  r.value = a - b;
                default: r.value = a + b;          // add, nop and unknown codes
            endcase
            r.reg_write = (opc inside {op_add, op_sub, op_and, op_or, op_xor, op_slt,
                                       op_addi}) && (d != 3'd0);
            r.branch_taken = (opc == op_beq && a == b) || (opc == op_bne && a != b);
            if (annul) begin
                annul = 1'b0;                      // never retires
            end else begin
                if (r.reg_write) begin
                    ref_regs[d] = r.value;
                end
                annul = r.branch_taken;
                exp_q.push_back(r);
                name_q.push_back(tbl_name[i]);
            end
        end
    endtask

    task automatic check_result(input string name, input result_t exp, input result_t act);
        if (act !== exp) begin
            mismatch_count++;
            $display("mismatch %s: expected pc=%h dest=%0d value=%h wr=%b taken=%b tgt=%h",
                     name, exp.pc, exp.dest, exp.value, exp.reg_write, exp.branch_taken,
                     exp.target);
            $display("  actual pc=%h dest=%0d value=%h wr=%b taken=%b tgt=%h", act.pc,
                     act.dest, act.value, act.reg_write, act.branch_taken, act.target);
        end
    endtask

    task automatic check_reg_value(input string name, input logic [isa_width-1:0] exp,
            input logic [isa_width-1:0] act);
        if (act !== exp) begin
            mismatch_count++;
            $display("mismatch %s: expected %h actual %h", name, exp, act);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;                     // 100 MHz
    end

    initial begin
        lfsr_state = 32'h9901_aa62;
        out_ready  = 1'b0;
        forever begin
            @(posedge clk);
            out_ready  <= lfsr_state[0];           // one bit per cycle
            lfsr_state = lfsr_next(lfsr_state);
        end
    end

    // retire monitor, every result checked against the queue front
    always @(posedge clk) begin
        result_t exp_r;
        string   nm;
        if (rst_n && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                other_count++;
                $display("unexpected output for pc %h with no result pending", out_data.pc);
            end else begin
                exp_r = exp_q.pop_front();
                nm    = name_q.pop_front();
                check_result(nm, exp_r, out_data);
            end
        end
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: %0d results still pending after %0d cycles", exp_q.size(),
                 watchdog_cycles);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        rst_n          = 1'b0;
        in_valid       = 1'b0;
        in_data        = '0;
        mismatch_count = 0;
        other_count    = 0;
        build_table();
        build_expected();
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        if (out_valid !== 1'b0 || in_ready !== 1'b1) begin
            other_count++;
            $display("out_valid or in_ready wrong right after reset");
        end
        for (int i = 0; i < num_tests; i++) begin
            in_valid <= 1'b1;                      // kept high so annul hits the next entry
            in_data  <= tbl[i];
            @(posedge clk);
            while (!in_ready) @(posedge clk);
        end
        in_valid <= 1'b0;
        while (exp_q.size() != 0) @(posedge clk);
        repeat (20) @(posedge clk);                // monitor flags any extra output
        for (int i = 0; i < num_regs; i++) begin
            check_reg_value($sformatf("r%0d", i), ref_regs[i],
                            core_pipe_i.reg_file_i.regs[reg_addr_width'(i)]);
        end
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
        if (mismatch_count + other_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: tb.f
source/pipe_pkg.sv
source/reg_file.sv
source/instr_decode.sv
source/id_ex_reg.sv
source/exec_unit.sv
source/result_reg.sv
source/core_pipe.sv
sim/core_pipe_asserts.sv
sim/core_pipe_tb.sv

// File: Makefile
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f tb.f --top-module core_pipe_tb -Mdir obj_dir -o core_pipe_sim

run: compile
	./obj_dir/core_pipe_sim | tee $(LOG)
	grep -q "^Done: no errors$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
